/* include/iigs_consts.svh */
`ifndef IIGS_CONSTS_SVH
`define IIGS_CONSTS_SVH

// low offsets within the C0xx page
`define IIGS_ADDR_STATEREG  8'h68
`define IIGS_ADDR_LC_BASE   8'h80   // language card window 80-8F
`define IIGS_ADDR_VGCINT    8'h23
`define IIGS_ADDR_VGCCLR    8'h32
`define IIGS_ADDR_INTEN     8'h41
`define IIGS_ADDR_INTFLAG   8'h46
`define IIGS_ADDR_INTCLR    8'h47
`define IIGS_ADDR_SHADOW    8'h35

// power-on register values
`define IIGS_RST_SHADOW     8'h08
`define IIGS_RST_TEXTCOLOR  8'hf2   // white on blue
`define IIGS_RST_NEWVIDEO   8'h41

// banks that see the I/O page and the aux mapping
`define IIGS_BANK_MAIN      8'h00
`define IIGS_BANK_FAST      8'he0

// interrupt tick timing
// short prescale so that simulation sees ticks quickly
`define IIGS_QTR_TICKS      20'd50
`define IIGS_QTRS_PER_SEC   3'd4

`endif

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module iigs_io_tb -o iigs_io_sim

out=$(./obj_dir/iigs_io_sim || true)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi

/* src/aux_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iigs_consts.svh"

module aux_mapper (
	input  wire iigs_pkg::cpu_addr_t cpu_addr,
	input  wire                      write,
	input  wire                      store80,
	input  wire                      ramrd,
	input  wire                      ramwrt,
	input  wire                      altzp,
	input  wire                      page2,
	input  wire                      hires,
	input  wire                      rdrom,
	input  wire                      lcram2,
	output iigs_pkg::cpu_addr_t      addr_bus,
	output logic                     aux
);

	logic [7:0]  bank;
	logic [15:0] off;
	logic        low_bank;
	logic        ram_sw;   // RAMRD or RAMWRT by direction
	logic        lc_remap;

	assign bank     = cpu_addr[23:16];
	assign off      = cpu_addr[15:0];
	assign low_bank = (bank == `IIGS_BANK_MAIN) | (bank == `IIGS_BANK_FAST);
	assign ram_sw   = write ? ramwrt : ramrd;

	always_comb begin
		if (!low_bank)
			aux = 1'b0;
		else if (off[15:9] == 7'd0 || off[15:14] == 2'b11)
			aux = altzp;   // zero page, stack and LC area
		else if (off[15:10] == 6'b000001)
			aux = store80 ? page2 : ram_sw;   // text page 1
		else if (off[15:13] == 3'b001)
			aux = (store80 & hires) ? page2 : ram_sw;   // hires page 1
		else
			aux = ram_sw;
	end

	// LC bank 2 sits below bank 1 in the RAM image
	assign lc_remap = low_bank & (off[15:12] == 4'hd) & lcram2 & ~rdrom;

	assign addr_bus = cpu_addr - (lc_remap ? 24'h001000 : 24'h000000) +
		(aux ? 24'h010000 : 24'h000000);

endmodule

`default_nettype wire

/* src/iigs_io.sv */
`timescale 1ns/1ps
`default_nettype none

module iigs_io (
	input  wire                 clk_sys,
	input  wire                 cpu_vda,
	input  wire                 acc,
	input  wire                 write,
	input  wire [7:0]           bank,
	input  wire [15:0]          addr,
	input  wire [7:0]           wdata,
	input  wire                 vblank,
	input  wire                 scanline_irq,
	input  wire                 vbl_irq,
	output logic [7:0]          rdata,
	output logic                rdata_valid,
	output logic                irq,
	output iigs_pkg::cpu_addr_t addr_bus,
	output logic                aux,
	output logic                rdrom,
	output logic                lcram2,
	output logic                lc_we,
	output logic                store80,
	output logic                ramrd,
	output logic                ramwrt,
	output logic                altzp,
	output logic                page2,
	output logic                hires,
	output logic                intcxrom,
	output logic                textg,
	output logic                mixg,
	output logic                eightycol,
	output logic                altcharset,
	output logic [7:0]          shadow,
	output logic [7:0]          textcolor,
	output logic [7:0]          newvideo,
	output logic [7:0]          sltromsel,
	output logic [3:0]          bordercolor
);

	logic       io_sel;
	logic       irq_hit;
	logic [7:0] irq_rdata;

	lang_card_fsm u_lc (
		.clk_sys (clk_sys),
		.cpu_vda (cpu_vda),
		.acc     (acc),
		.write   (write),
		.io_sel  (io_sel),
		.addr    (addr[7:0]),
		.wdata   (wdata),
		.rdrom   (rdrom),
		.lcram2  (lcram2),
		.lc_we   (lc_we)
	);

	irq_ctrl u_irq (
		.clk_sys      (clk_sys),
		.cpu_vda      (cpu_vda),
		.acc          (acc),
		.write        (write),
		.io_sel       (io_sel),
		.addr         (addr[7:0]),
		.wdata        (wdata),
		.scanline_irq (scanline_irq),
		.vbl_irq      (vbl_irq),
		.irq_hit      (irq_hit),
		.irq_rdata    (irq_rdata),
		.irq          (irq)
	);

	softswitch_regs u_regs (
		.clk_sys     (clk_sys),
		.cpu_vda     (cpu_vda),
		.acc         (acc),
		.write       (write),
		.bank        (bank),
		.addr        (addr),
		.wdata       (wdata),
		.vblank      (vblank),
		.rdrom       (rdrom),
		.lcram2      (lcram2),
		.irq_hit     (irq_hit),
		.irq_rdata   (irq_rdata),
		.io_sel      (io_sel),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.store80     (store80),
		.ramrd       (ramrd),
		.ramwrt      (ramwrt),
		.altzp       (altzp),
		.page2       (page2),
		.hires       (hires),
		.intcxrom    (intcxrom),
		.textg       (textg),
		.mixg        (mixg),
		.eightycol   (eightycol),
		.altcharset  (altcharset),
		.shadow      (shadow),
		.textcolor   (textcolor),
		.newvideo    (newvideo),
		.sltromsel   (sltromsel),
		.bordercolor (bordercolor)
	);

	aux_mapper u_map (
		.cpu_addr ({bank, addr}),
		.write    (write),
		.store80  (store80),
		.ramrd    (ramrd),
		.ramwrt   (ramwrt),
		.altzp    (altzp),
		.page2    (page2),
		.hires    (hires),
		.rdrom    (rdrom),
		.lcram2   (lcram2),
		.addr_bus (addr_bus),
		.aux      (aux)
	);

endmodule

`default_nettype wire

/* src/iigs_pkg.sv */
`default_nettype none

package iigs_pkg;

	// full 24-bit CPU address, bank in 23:16
	typedef logic [23:0] cpu_addr_t;

	// low byte of a C0xx address
	typedef logic [7:0] io_reg_t;

	// $C068 state register, seen as a byte or as its switches
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic altzp;     // bit 7
			logic page2;
			logic ramrd;
			logic ramwrt;
			logic rdrom;
			logic lcram2;
			logic rombank;
			logic intcxrom;  // bit 0
		} fields;
	} state_reg_u;

endpackage

`default_nettype wire

/* src/irq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iigs_consts.svh"

module irq_ctrl (
	input  wire                    clk_sys,
	input  wire                    cpu_vda,
	input  wire                    acc,
	input  wire                    write,
	input  wire                    io_sel,
	input  wire iigs_pkg::io_reg_t addr,
	input  wire [7:0]              wdata,
	input  wire                    scanline_irq,
	input  wire                    vbl_irq,
	output logic                   irq_hit,
	output logic [7:0]             irq_rdata,
	output logic                   irq
);

	logic [7:0] vgcint;    // 7 any, 6 second, 5 scanline, 2:1 enables
	logic [7:0] inten;
	logic [7:0] intflag;   // 4 quarter second, 3 vbl
	logic       qtr_tick;
	logic       sec_tick;
	logic       hit_vgc, hit_clr, hit_en, hit_flag, hit_ack;

	irq_timer u_timer (
		.clk_sys  (clk_sys),
		.cpu_vda  (cpu_vda),
		.qtr_tick (qtr_tick),
		.sec_tick (sec_tick)
	);

	assign hit_vgc  = io_sel & (addr == `IIGS_ADDR_VGCINT);
	assign hit_clr  = io_sel & (addr == `IIGS_ADDR_VGCCLR);
	assign hit_en   = io_sel & (addr == `IIGS_ADDR_INTEN);
	assign hit_flag = io_sel & (addr == `IIGS_ADDR_INTFLAG);
	assign hit_ack  = io_sel & (addr == `IIGS_ADDR_INTCLR);
	assign irq_hit  = hit_vgc | hit_clr | hit_en | hit_flag | hit_ack;

	always_comb begin
		irq_rdata = 8'h00;   // 32 and 47 read as zero
		if (hit_vgc)
			irq_rdata = vgcint;
		else if (hit_en)
			irq_rdata = inten;
		else if (hit_flag)
			irq_rdata = intflag;
	end

	assign irq = (vgcint[6] & vgcint[2]) | (vgcint[5] & vgcint[1]) |
		(intflag[3] & inten[3]) | (intflag[4] & inten[4]);

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			vgcint  <= 8'h00;
			inten   <= 8'h00;
			intflag <= 8'h00;
		end else begin
			if (acc && write && hit_vgc)
				vgcint[2:1] <= wdata[2:1];   // only the enables are writable
			if (acc && write && hit_clr) begin
				// zero bits in the data clear the matching flag
				if (!wdata[6])
					vgcint[6] <= 1'b0;
				if (!wdata[5])
					vgcint[5] <= 1'b0;
				if ((!vgcint[5] || !wdata[5]) && (!vgcint[6] || !wdata[6]))
					vgcint[7] <= 1'b0;
			end
			if (acc && write && hit_en)
				inten[4:0] <= wdata[4:0];
			if (acc && hit_ack)
				intflag[4:3] <= 2'b00;   // read or write acks

			// new events win over a clear in the same cycle
			if (scanline_irq) begin
				vgcint[5] <= 1'b1;
				if (vgcint[1])
					vgcint[7] <= 1'b1;
			end
			if (sec_tick && vgcint[2]) begin
				vgcint[6] <= 1'b1;
				vgcint[7] <= 1'b1;
			end
			if (vbl_irq && inten[3])
				intflag[3] <= 1'b1;
			if (qtr_tick && inten[4])
				intflag[4] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/irq_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iigs_consts.svh"

module irq_timer (
	input  wire  clk_sys,
	input  wire  cpu_vda,
	output logic qtr_tick,
	output logic sec_tick
);

	logic [19:0] prescale;
	logic [2:0]  qtr_cnt;    // quarters seen in the current second
	logic        pre_wrap;

	assign pre_wrap = (prescale == `IIGS_QTR_TICKS - 20'd1);

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			prescale <= 20'd0;
			qtr_cnt  <= 3'd0;
			qtr_tick <= 1'b0;
			sec_tick <= 1'b0;
		end else begin
			qtr_tick <= pre_wrap;
			sec_tick <= 1'b0;
			if (pre_wrap) begin
				prescale <= 20'd0;
				if (qtr_cnt == `IIGS_QTRS_PER_SEC - 3'd1) begin
					qtr_cnt  <= 3'd0;
					sec_tick <= 1'b1;   // lands with the fourth quarter
				end else begin
					qtr_cnt <= qtr_cnt + 3'd1;
				end
			end else begin
				prescale <= prescale + 20'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/lang_card_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iigs_consts.svh"

module lang_card_fsm (
	input  wire                   clk_sys,
	input  wire                   cpu_vda,
	input  wire                   acc,
	input  wire                   write,
	input  wire                   io_sel,
	input  wire iigs_pkg::io_reg_t addr,
	input  wire [7:0]             wdata,
	output logic                  rdrom,
	output logic                  lcram2,
	output logic                  lc_we
);

	logic lc_we_pre;   // one odd read seen
	logic lc_hit;
	logic st_wr;
	iigs_pkg::state_reg_u st_in;

	// any access to 80-8F
	assign lc_hit = acc & io_sel & ((addr & 8'hf0) == `IIGS_ADDR_LC_BASE);

	// write to the state register also moves the LC bank bits
	assign st_wr = acc & io_sel & write & (addr == `IIGS_ADDR_STATEREG);

	always_comb begin
		st_in.raw = wdata;
	end

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			rdrom     <= 1'b1;
			lcram2    <= 1'b0;
			lc_we     <= 1'b0;
			lc_we_pre <= 1'b0;
		end else if (lc_hit) begin
			rdrom  <= addr[0] ^ addr[1];   // x1 and x2 read ROM
			lcram2 <= ~addr[3];            // 80-87 map bank 2
			if (!write && addr[0]) begin
				// second odd read in a row opens writes
				lc_we     <= lc_we_pre;
				lc_we_pre <= 1'b1;
			end else begin
				lc_we     <= 1'b0;
				lc_we_pre <= 1'b0;
			end
		end else if (st_wr) begin
			rdrom  <= st_in.fields.rdrom;
			lcram2 <= st_in.fields.lcram2;
		end
	end

endmodule

`default_nettype wire

/* src/softswitch_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iigs_consts.svh"

module softswitch_regs (
	input  wire        clk_sys,
	input  wire        cpu_vda,
	input  wire        acc,
	input  wire        write,
	input  wire [7:0]  bank,
	input  wire [15:0] addr,
	input  wire [7:0]  wdata,
	input  wire        vblank,
	input  wire        rdrom,
	input  wire        lcram2,
	input  wire        irq_hit,
	input  wire [7:0]  irq_rdata,
	output logic       io_sel,
	output logic [7:0] rdata,
	output logic       rdata_valid,
	output logic       store80,
	output logic       ramrd,
	output logic       ramwrt,
	output logic       altzp,
	output logic       page2,
	output logic       hires,
	output logic       intcxrom,
	output logic       textg,
	output logic       mixg,
	output logic       eightycol,
	output logic       altcharset,
	output logic [7:0] shadow,
	output logic [7:0] textcolor,
	output logic [7:0] newvideo,
	output logic [7:0] sltromsel,
	output logic [3:0] bordercolor
);

	iigs_pkg::io_reg_t    lo;
	iigs_pkg::state_reg_u st_in;
	iigs_pkg::state_reg_u st_rd;
	logic       bank_ok;
	logic       rd, wr;
	logic       pair_rd;   // switches that also flip on a read
	logic       slotc3rom;
	logic [7:0] monochrome;
	logic [7:0] rd_mux;

	assign lo = addr[7:0];

	// banks 00, 01, E0 and E1
	assign bank_ok = ((bank & 8'hfe) == `IIGS_BANK_MAIN) | ((bank & 8'hfe) == `IIGS_BANK_FAST);
	assign io_sel  = bank_ok & (shadow[6] ? (addr[15:13] == 3'b110) : (addr[15:8] == 8'hc0));

	assign rd      = acc & io_sel & ~write;
	assign wr      = acc & io_sel & write;
	assign pair_rd = (lo[7:1] == 7'b0000001) | (lo[7:1] == 7'b0000010) |   // 02-05
		(lo[7:3] == 5'b01010);   // 50-57

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			store80     <= 1'b0;
			ramrd       <= 1'b0;
			ramwrt      <= 1'b0;
			intcxrom    <= 1'b0;
			altzp       <= 1'b0;
			slotc3rom   <= 1'b0;
			eightycol   <= 1'b0;
			altcharset  <= 1'b0;
			textg       <= 1'b0;
			mixg        <= 1'b0;
			page2       <= 1'b0;
			hires       <= 1'b0;
			monochrome  <= 8'h00;
			shadow      <= `IIGS_RST_SHADOW;
			textcolor   <= `IIGS_RST_TEXTCOLOR;
			newvideo    <= `IIGS_RST_NEWVIDEO;
			sltromsel   <= 8'h00;
			bordercolor <= 4'h0;
		end else begin
			// odd address sets a paired switch
			if (wr || (rd && pair_rd)) begin
				case (lo)
					8'h00, 8'h01: store80    <= lo[0];
					8'h02, 8'h03: ramrd      <= lo[0];
					8'h04, 8'h05: ramwrt     <= lo[0];
					8'h06, 8'h07: intcxrom   <= lo[0];
					8'h08, 8'h09: altzp      <= lo[0];
					8'h0a, 8'h0b: slotc3rom  <= lo[0];
					8'h0c, 8'h0d: eightycol  <= lo[0];
					8'h0e, 8'h0f: altcharset <= lo[0];
					8'h50, 8'h51: textg      <= lo[0];
					8'h52, 8'h53: mixg       <= lo[0];
					8'h54, 8'h55: page2      <= lo[0];
					8'h56, 8'h57: hires      <= lo[0];
					default: ;
				endcase
			end
			if (wr) begin
				case (lo)
					8'h21: monochrome <= wdata;
					8'h22: textcolor  <= wdata;
					8'h29: newvideo   <= wdata;
					8'h2d: sltromsel  <= wdata;
					8'h34: bordercolor <= wdata[3:0];   // low nibble only
					`IIGS_ADDR_SHADOW: shadow <= wdata;
					`IIGS_ADDR_STATEREG: begin
						// rdrom and lcram2 live in the language card
						altzp    <= st_in.fields.altzp;
						page2    <= st_in.fields.page2;
						ramrd    <= st_in.fields.ramrd;
						ramwrt   <= st_in.fields.ramwrt;
						intcxrom <= st_in.fields.intcxrom;
					end
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		st_in.raw = wdata;

		st_rd.fields.altzp    = altzp;
		st_rd.fields.page2    = page2;
		st_rd.fields.ramrd    = ramrd;
		st_rd.fields.ramwrt   = ramwrt;
		st_rd.fields.rdrom    = rdrom;
		st_rd.fields.lcram2   = lcram2;
		st_rd.fields.rombank  = 1'b0;   // no ROM bank switching
		st_rd.fields.intcxrom = intcxrom;

		rd_mux = 8'h00;
		if (irq_hit) begin
			rd_mux = irq_rdata;
		end else begin
			case (lo)
				8'h11: rd_mux = {lcram2, 7'd0};
				8'h12: rd_mux = {rdrom, 7'd0};
				8'h13: rd_mux = {ramrd, 7'd0};
				8'h14: rd_mux = {ramwrt, 7'd0};
				8'h15: rd_mux = {intcxrom, 7'd0};
				8'h16: rd_mux = {altzp, 7'd0};
				8'h17: rd_mux = {slotc3rom, 7'd0};
				8'h18: rd_mux = {store80, 7'd0};
				8'h19: rd_mux = {~vblank, 7'd0};   // high outside blanking
				8'h1a: rd_mux = {textg, 7'd0};
				8'h1b: rd_mux = {mixg, 7'd0};
				8'h1c: rd_mux = {page2, 7'd0};
				8'h1d: rd_mux = {hires, 7'd0};
				8'h1e: rd_mux = {altcharset, 7'd0};
				8'h1f: rd_mux = {eightycol, 7'd0};
				8'h21: rd_mux = monochrome;
				8'h22: rd_mux = textcolor;
				8'h29: rd_mux = newvideo;
				8'h2d: rd_mux = sltromsel;
				`IIGS_ADDR_SHADOW: rd_mux = shadow;
				`IIGS_ADDR_STATEREG: rd_mux = st_rd.raw;
				default: rd_mux = 8'h00;
			endcase
		end
	end

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda)
			rdata_valid <= 1'b0;
		else
			rdata_valid <= rd;
	end

	always_ff @(posedge clk_sys) begin
		if (rd)
			rdata <= rd_mux;
	end

endmodule

`default_nettype wire

/* verification/iigs_io_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module iigs_io_chk (
	input wire       clk_sys,
	input wire       cpu_vda,
	input wire       irq,
	input wire       rdata_valid,
	input wire [7:0] vgcint,
	input wire [7:0] inten,
	input wire [7:0] intflag
);

	// request is each flag gated by its enable
	a_irq_or: assert property (@(posedge clk_sys) disable iff (cpu_vda)
		irq == ((vgcint[6] & vgcint[2]) | (vgcint[5] & vgcint[1]) |
			(intflag[3] & inten[3]) | (intflag[4] & inten[4])))
		else $error("irq differs from the enabled flags");

	// summary bit needs a source flag
	a_vgc_sum: assert property (@(posedge clk_sys) disable iff (cpu_vda)
		$rose(vgcint[7]) |-> (vgcint[5] || vgcint[6]))
		else $error("VGCINT bit 7 rose with bits 6 and 5 clear");

	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (cpu_vda)
		rdata_valid |=> !rdata_valid)
		else $error("rdata_valid held for two cycles");

endmodule

bind iigs_io iigs_io_chk chk0 (
	.clk_sys     (clk_sys),
	.cpu_vda     (cpu_vda),
	.irq         (irq),
	.rdata_valid (rdata_valid),
	.vgcint      (u_irq.vgcint),
	.inten       (u_irq.inten),
	.intflag     (u_irq.intflag)
);

`default_nettype wire

/* verification/iigs_io_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iigs_consts.svh"

module iigs_io_tb;

	localparam int NACC = 1404;   // accesses over all phases

	logic clk_sys, cpu_vda, acc, write, vblank, scanline_irq, vbl_irq;
	logic [7:0] bank, wdata, rdata, shadow, textcolor, newvideo, sltromsel;
	logic [15:0] addr;
	logic [3:0] bordercolor;
	logic rdata_valid, irq, aux, rdrom, lcram2, lc_we, store80, ramrd, ramwrt;
	logic altzp, page2, hires, intcxrom, textg, mixg, eightycol, altcharset;
	logic [23:0] addr_bus;

	// reference model state
	logic [15:0] m_sw;   // 0 store80 1 ramrd 2 ramwrt 3 intcx 4 altzp 5 c3rom 6 80col 7 altchr
	logic m_rdrom, m_lcram2, m_we, m_pre, e_valid, m_qtr, m_sec;   // 8 textg 9 mixg 10 page2 11 hires
	logic [7:0] m_mono, m_shadow, m_tcol, m_nvid, m_slt, m_vgc, m_inten, m_flag, e_rdata;
	logic [3:0] m_border;
	logic [19:0] m_pcnt;
	logic [2:0] m_qcnt;

	integer seed = 32'h707e;
	integer nerrors = 0;
	integer nchecks = 0;
	logic [31:0] r;

	iigs_io dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	function automatic logic [7:0] read_model(input logic [7:0] lo);
		case (lo)
			8'h11: read_model = {m_lcram2, 7'd0};
			8'h12: read_model = {m_rdrom, 7'd0};
			8'h13: read_model = {m_sw[1], 7'd0};
			8'h14: read_model = {m_sw[2], 7'd0};
			8'h15: read_model = {m_sw[3], 7'd0};
			8'h16: read_model = {m_sw[4], 7'd0};
			8'h17: read_model = {m_sw[5], 7'd0};
			8'h18: read_model = {m_sw[0], 7'd0};
			8'h19: read_model = {~vblank, 7'd0};
			8'h1a: read_model = {m_sw[8], 7'd0};
			8'h1b: read_model = {m_sw[9], 7'd0};
			8'h1c: read_model = {m_sw[10], 7'd0};
			8'h1d: read_model = {m_sw[11], 7'd0};
			8'h1e: read_model = {m_sw[7], 7'd0};
			8'h1f: read_model = {m_sw[6], 7'd0};
			8'h21: read_model = m_mono;
			8'h22: read_model = m_tcol;
			8'h23: read_model = m_vgc;
			8'h29: read_model = m_nvid;
			8'h2d: read_model = m_slt;
			8'h35: read_model = m_shadow;
			8'h41: read_model = m_inten;
			8'h46: read_model = m_flag;
			8'h68: read_model = {m_sw[4], m_sw[10], m_sw[1], m_sw[2], m_rdrom, m_lcram2,
				1'b0, m_sw[3]};
			default: read_model = 8'h00;
		endcase
	endfunction

	function automatic logic aux_model(input logic [7:0] bk, input logic [15:0] off,
		input logic w);
		logic ram;
		ram = w ? m_sw[2] : m_sw[1];
		if (bk != `IIGS_BANK_MAIN && bk != `IIGS_BANK_FAST)
			aux_model = 1'b0;
		else if (off[15:8] <= 8'h01 || off[15:8] >= 8'hc0)
			aux_model = m_sw[4];
		else if (off[15:8] >= 8'h04 && off[15:8] <= 8'h07)
			aux_model = m_sw[0] ? m_sw[10] : ram;
		else if (off[15:8] >= 8'h20 && off[15:8] <= 8'h3f)
			aux_model = (m_sw[0] && m_sw[11]) ? m_sw[10] : ram;
		else
			aux_model = ram;
	endfunction

	function automatic logic [23:0] map_model(input logic [7:0] bk, input logic [15:0] off,
		input logic w);
		logic low;
		logic [23:0] a;
		low = (bk == `IIGS_BANK_MAIN) || (bk == `IIGS_BANK_FAST);
		a = {bk, off};
		if (low && off[15:12] == 4'hd && m_lcram2 && !m_rdrom)
			a = a - 24'h001000;   // LC bank 2 below bank 1
		if (aux_model(bk, off, w))
			a = a + 24'h010000;
		map_model = a;
	endfunction

	always @(posedge clk_sys or posedge cpu_vda) begin : model
		logic io, rd, wr, n5, n6;
		logic [7:0] lo, old_vgc, old_en;
		if (cpu_vda) begin
			m_sw = 16'h0000;
			{m_rdrom, m_lcram2, m_we, m_pre, e_valid, m_qtr, m_sec} = 7'b1000000;
			{m_mono, m_slt, m_vgc, m_inten, m_flag, e_rdata} = 48'd0;
			m_shadow = `IIGS_RST_SHADOW;
			m_tcol = `IIGS_RST_TEXTCOLOR;
			m_nvid = `IIGS_RST_NEWVIDEO;
			m_border = 4'h0;
			m_pcnt = 20'd0;
			m_qcnt = 3'd0;
		end else begin
			lo = addr[7:0];
			old_vgc = m_vgc;
			old_en = m_inten;
			io = (bank == 8'h00 || bank == 8'h01 || bank == 8'he0 || bank == 8'he1) &&
				(m_shadow[6] ? (addr[15:13] == 3'b110) : (addr[15:8] == 8'hc0));
			rd = acc && io && !write;
			wr = acc && io && write;
			e_valid = rd;
			if (rd)
				e_rdata = read_model(lo);
			if (wr || (rd && ((lo >= 8'h02 && lo <= 8'h05) || (lo >= 8'h50 && lo <= 8'h57)))) begin
				if (lo <= 8'h0f)
					m_sw[{1'b0, lo[3:1]}] = lo[0];
				else if (lo >= 8'h50 && lo <= 8'h57)
					m_sw[{2'b10, lo[2:1]}] = lo[0];
			end
			if (wr) begin
				case (lo)
					8'h21: m_mono = wdata;
					8'h22: m_tcol = wdata;
					8'h29: m_nvid = wdata;
					8'h2d: m_slt = wdata;
					8'h34: m_border = wdata[3:0];
					8'h35: m_shadow = wdata;
					8'h68: begin
						m_sw[4] = wdata[7];
						m_sw[10] = wdata[6];
						m_sw[1] = wdata[5];
						m_sw[2] = wdata[4];
						m_sw[3] = wdata[0];
					end
					default: ;
				endcase
			end
			// two odd language card reads open writes
			if (acc && io && lo[7:4] == 4'h8) begin
				m_rdrom = lo[0] ^ lo[1];
				m_lcram2 = !lo[3];
				if (!write && lo[0]) begin
					m_we = m_pre;
					m_pre = 1'b1;
				end else begin
					m_we = 1'b0;
					m_pre = 1'b0;
				end
			end else if (wr && lo == 8'h68) begin
				m_rdrom = wdata[3];
				m_lcram2 = wdata[2];
			end
			if (wr && lo == 8'h23)
				m_vgc[2:1] = wdata[2:1];
			if (wr && lo == 8'h32) begin
				n5 = m_vgc[5] & wdata[5];
				n6 = m_vgc[6] & wdata[6];
				m_vgc[5] = n5;
				m_vgc[6] = n6;
				if (!n5 && !n6)
					m_vgc[7] = 1'b0;
			end
			if (wr && lo == 8'h41)
				m_inten[4:0] = wdata[4:0];
			if (acc && io && lo == 8'h47)
				m_flag[4:3] = 2'b00;
			if (scanline_irq) begin
				m_vgc[5] = 1'b1;
				if (old_vgc[1])
					m_vgc[7] = 1'b1;
			end
			if (m_sec && old_vgc[2])
				m_vgc[7:6] = 2'b11;
			if (vbl_irq && old_en[3])
				m_flag[3] = 1'b1;
			if (m_qtr && old_en[4])
				m_flag[4] = 1'b1;
			// tick period rule
			m_qtr = 1'b0;
			m_sec = 1'b0;
			if (m_pcnt == `IIGS_QTR_TICKS - 20'd1) begin
				m_pcnt = 20'd0;
				m_qtr = 1'b1;
				if (m_qcnt == `IIGS_QTRS_PER_SEC - 3'd1) begin
					m_qcnt = 3'd0;
					m_sec = 1'b1;
				end else begin
					m_qcnt = m_qcnt + 3'd1;
				end
			end else begin
				m_pcnt = m_pcnt + 20'd1;
			end
		end
	end

	task automatic chk1(input string name, input logic got, input logic exp);
		nchecks = nchecks + 1;
		if (got !== exp) begin
			nerrors = nerrors + 1;
			$display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic chk8(input string name, input logic [7:0] got, input logic [7:0] exp);
		nchecks = nchecks + 1;
		if (got !== exp) begin
			nerrors = nerrors + 1;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic chk24(input string name, input logic [23:0] got, input logic [23:0] exp);
		nchecks = nchecks + 1;
		if (got !== exp) begin
			nerrors = nerrors + 1;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// outputs settle between edges
	always @(negedge clk_sys) begin
		if (!cpu_vda) begin
			chk1("rdata_valid", rdata_valid, e_valid);
			if (e_valid)
				chk8("rdata", rdata, e_rdata);
			chk1("irq", irq, (m_vgc[6] & m_vgc[2]) | (m_vgc[5] & m_vgc[1]) |
				(m_flag[3] & m_inten[3]) | (m_flag[4] & m_inten[4]));
			chk1("lc_we", lc_we, m_we);
			chk1("rdrom", rdrom, m_rdrom);
			chk1("lcram2", lcram2, m_lcram2);
			chk8("switches", {store80, ramrd, ramwrt, intcxrom, altzp, eightycol, altcharset,
				textg}, {m_sw[0], m_sw[1], m_sw[2], m_sw[3], m_sw[4], m_sw[6], m_sw[7], m_sw[8]});
			chk8("mixg_page2_hires", {5'd0, mixg, page2, hires}, {5'd0, m_sw[9], m_sw[10], m_sw[11]});
			chk8("shadow", shadow, m_shadow);
			chk8("textcolor", textcolor, m_tcol);
			chk8("newvideo", newvideo, m_nvid);
			chk8("sltromsel", sltromsel, m_slt);
			chk8("bordercolor", {4'h0, bordercolor}, {4'h0, m_border});
			chk1("aux", aux, aux_model(bank, addr, write));
			chk24("addr_bus", addr_bus, map_model(bank, addr, write));
		end
	end

	// one access followed by an idle cycle
	task automatic access(input logic a, input logic w, input logic [7:0] bk,
		input logic [15:0] ad, input logic [7:0] wd, input logic sl, input logic vb);
		@(posedge clk_sys);
		acc <= a;
		write <= w;
		bank <= bk;
		addr <= ad;
		wdata <= wd;
		scanline_irq <= sl;
		vbl_irq <= vb;
		@(posedge clk_sys);
		acc <= 1'b0;
		scanline_irq <= 1'b0;
		vbl_irq <= 1'b0;
	endtask

	initial begin
		#(NACC * 3 * 40 + 4000);
		$display("Error: watchdog expired before all accesses completed");
		$display("test failed");
		$finish;
	end

	initial begin
		{acc, write, vblank, scanline_irq, vbl_irq} = 5'b00000;
		bank = 8'h00;
		addr = 16'h0000;
		wdata = 8'h00;
		cpu_vda = 1'b1;
		repeat (3) @(posedge clk_sys);
		cpu_vda <= 1'b0;
		// reset values
		access(1'b1, 1'b0, 8'h00, 16'hc035, 8'h00, 1'b0, 1'b0);
		access(1'b1, 1'b0, 8'h00, 16'hc022, 8'h00, 1'b0, 1'b0);
		access(1'b1, 1'b0, 8'h00, 16'hc029, 8'h00, 1'b0, 1'b0);
		access(1'b1, 1'b0, 8'h00, 16'hc068, 8'h00, 1'b0, 1'b0);
		repeat (400) begin
			r = $random(seed);
			vblank <= r[20];
			access(1'b1, r[7], {{3{r[9]}}, 4'h0, r[8]},
				{8'hc0, (r[6:0] < 7'd96) ? {1'b0, r[6:0]} : 8'h68}, r[31:24], 1'b0, 1'b0);
		end
		repeat (300) begin
			r = $random(seed);
			access(1'b1, r[5:4] == 2'b00, 8'h00, {12'hc08, r[3:0]}, r[15:8], 1'b0, 1'b0);
		end
		repeat (300) begin
			r = $random(seed);
			if (r[0])
				access(1'b1, 1'b1, 8'h00, {8'hc0, r[1] ? {4'h5, 1'b0, r[4:2]} : {4'h0, r[5:2]}},
					8'h00, 1'b0, 1'b0);
			else
				access(1'b0, r[1], r[2] ? 8'h01 : {{3{r[3]}}, 5'd0}, r[31:16], 8'h00, 1'b0, 1'b0);
		end
		repeat (400) begin
			r = $random(seed);
			case (r[2:0])
				3'd0, 3'd5: addr <= 16'hc023;
				3'd1: addr <= 16'hc032;
				3'd2, 3'd6: addr <= 16'hc041;
				3'd3, 3'd7: addr <= 16'hc046;
				default: addr <= 16'hc047;
			endcase
			@(negedge clk_sys);
			access(1'b1, r[3], 8'h00, addr, r[15:8], r[4] & r[5], r[6] & r[7]);
		end
		repeat (2) @(posedge clk_sys);
		$display("checks=%0d errors=%0d", nchecks, nerrors);
		if (nerrors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
src/iigs_pkg.sv
src/lang_card_fsm.sv
src/irq_timer.sv
src/irq_ctrl.sv
src/softswitch_regs.sv
src/aux_mapper.sv
src/iigs_io.sv
verification/iigs_io_chk.sv
verification/iigs_io_tb.sv
